//--- tb.f
+incdir+tb
source/ao_periph_pkg.sv
source/obi_to_reg.sv
source/reg_demux.sv
source/soc_ctrl.sv
source/rv_timer.sv
source/power_manager.sv
source/ao_peripheral_subsystem.sv
tb/tb_ao_peripheral_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

TOP=tb_ao_peripheral_subsystem
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
  --top-module "$TOP" -f tb.f -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./obj_dir/V$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi
echo "Simulation finished without failures"
exit 0

//--- tb/ao_ref_model.svh
// ====================
// Reference model for the AO peripheral testbench:
// register shadow, xorshift and address helpers
// ====================
`ifndef AO_REF_MODEL_SVH
`define AO_REF_MODEL_SVH

logic        m_exit_valid;
logic [31:0] m_exit_value;
logic [63:0] m_cmp;
logic        m_boot_sel;
logic [31:0] rng_state;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic logic [31:0] next_random();
  rng_state = xorshift32(rng_state);
  return rng_state;
endfunction

// Lanes with their strobe set take the new byte
function automatic logic [31:0] byte_merge(input logic [31:0] old_val,
                                           input logic [31:0] new_val,
                                           input logic [3:0]  be);
  logic [31:0] mask;
  mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  return (old_val & ~mask) | (new_val & mask);
endfunction

function automatic void model_reset();
  m_exit_valid = 1'b0;
  m_exit_value = 32'h0;
  m_cmp        = '1;
  m_boot_sel   = 1'b0;
endfunction

function automatic void model_write(input int unsigned idx, input logic [11:0] ofs,
                                    input logic [3:0] be, input logic [31:0] wdata);
  if (idx == SOC_CTRL_IDX) begin
    if (ofs == SOC_EXIT_VALID_OFS && be[0]) m_exit_valid = wdata[0];
    if (ofs == SOC_EXIT_VALUE_OFS) m_exit_value = byte_merge(m_exit_value, wdata, be);
  end else if (idx == TIMER_IDX) begin
    if (ofs == TMR_CMP_LO_OFS) m_cmp[31:0] = byte_merge(m_cmp[31:0], wdata, be);
    if (ofs == TMR_CMP_HI_OFS) m_cmp[63:32] = byte_merge(m_cmp[63:32], wdata, be);
  end
endfunction

function automatic logic [31:0] expected_read(input int unsigned idx, input logic [11:0] ofs);
  logic [31:0] val;
  val = 32'h0;
  if (idx == SOC_CTRL_IDX) begin
    if (ofs == SOC_EXIT_VALID_OFS) val = {31'h0, m_exit_valid};
    if (ofs == SOC_EXIT_VALUE_OFS) val = m_exit_value;
    if (ofs == SOC_BOOT_SEL_OFS) val = {31'h0, m_boot_sel};
  end else if (idx == TIMER_IDX) begin
    if (ofs == TMR_CMP_LO_OFS) val = m_cmp[31:0];
    if (ofs == TMR_CMP_HI_OFS) val = m_cmp[63:32];
  end
  return val;
endfunction

function automatic logic [31:0] periph_addr(input int unsigned idx, input logic [11:0] ofs);
  return AO_BASE + (idx << PERIPH_WINDOW_BITS) + {20'h0, ofs};
endfunction

`endif

//--- tb/tb_ao_peripheral_subsystem.sv
// ====================
// Testbench for the always-on peripheral subsystem
// ====================
`default_nettype none

module tb_ao_peripheral_subsystem
  import ao_periph_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned CLK_PERIOD = 40;
  localparam int unsigned N_RAND = 200;
  localparam int unsigned N_BOOT = 8;
  localparam int unsigned N_UNMAPPED = 16;
  localparam int unsigned MTIME_POLL_MAX = 100;
  localparam int unsigned SLEEP_BOUND = 400;
  localparam int unsigned TXN_COUNT = 12 + N_RAND + 3 * N_BOOT + N_UNMAPPED + MTIME_POLL_MAX + 16;
  localparam int unsigned WATCHDOG_CYCLES = 40 * TXN_COUNT + SLEEP_BOUND;

  logic                          clk_i;
  logic                          arst_n_i;
  obi_req_t                      obi_req;
  obi_resp_t                     obi_resp;
  logic                          boot_select;
  logic                          exit_valid;
  logic [31:0]                   exit_value;
  logic                          core_sleep;
  logic                          pg_switch;
  logic                          cpu_rst_n;
  logic                          timer_irq;
  int unsigned                   cycle_cnt = 0;
  int unsigned                   last_grant_cycle;
  int unsigned                   tgt_idx[4];
  logic [PERIPH_WINDOW_BITS-1:0] tgt_ofs[4];

  `include "ao_ref_model.svh"

  ao_peripheral_subsystem UUT (
    .clk_i                           (clk_i),
    .arst_n_i                        (arst_n_i),
    .slave_req_i                     (obi_req),
    .slave_resp_o                    (obi_resp),
    .boot_select_i                   (boot_select),
    .exit_valid_o                    (exit_valid),
    .exit_value_o                    (exit_value),
    .core_sleep_i                    (core_sleep),
    .cpu_subsystem_powergate_switch_o(pg_switch),
    .cpu_subsystem_rst_no            (cpu_rst_n),
    .rv_timer_irq_o                  (timer_irq)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the test sequence did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[FAIL] %0d ns: %s: got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic obi_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(negedge clk_i);
    obi_req.req   = 1'b1;
    obi_req.we    = we;
    obi_req.be    = be;
    obi_req.addr  = addr;
    obi_req.wdata = wdata;
    #1;
    while (!obi_resp.gnt) begin
      @(negedge clk_i);
      #1;
    end
    last_grant_cycle = cycle_cnt;
    // Response was registered at the grant edge
    @(negedge clk_i);
    check_equal(64'(obi_resp.rvalid), 64'd1, "rvalid one cycle after grant");
    rdata   = obi_resp.rdata;
    err     = obi_resp.err;
    obi_req = '0;
  endtask

  task automatic obi_write(input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        err;
    obi_access(1'b1, be, addr, wdata, rdata, err);
    check_equal(64'(err), 64'd0, "write error flag");
    check_equal(64'(rdata), 64'd0, "write response data");
  endtask

  task automatic obi_read(input logic [31:0] addr, output logic [31:0] rdata);
    logic err;
    obi_access(1'b0, 4'hF, addr, 32'h0, rdata, err);
    check_equal(64'(err), 64'd0, "read error flag");
  endtask

  task automatic read_expect(input int unsigned idx, input logic [11:0] ofs, input string what);
    logic [31:0] rdata;
    obi_read(periph_addr(idx, ofs), rdata);
    check_equal(64'(rdata), 64'(expected_read(idx, ofs)), what);
  endtask

  task automatic check_exit_outputs();
    check_equal(64'(exit_valid), 64'(m_exit_valid), "exit_valid_o");
    check_equal(64'(exit_value), 64'(m_exit_value), "exit_value_o");
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] rdata;
    logic [31:0] addr;
    logic        err;
    logic        reached;
    int unsigned presc;
    int unsigned m1;
    int unsigned m2;
    int unsigned t1;
    int unsigned t2;
    int unsigned cmp_lo;
    int unsigned polls;
    int unsigned cyc;
    int unsigned rst_fall;
    int unsigned sw_rise;
    int unsigned irq_seen;
    int unsigned sw_fall;
    int unsigned rst_rise;

    rng_state   = 32'h610a_265f;
    tgt_idx     = '{SOC_CTRL_IDX, SOC_CTRL_IDX, TIMER_IDX, TIMER_IDX};
    tgt_ofs     = '{SOC_EXIT_VALID_OFS, SOC_EXIT_VALUE_OFS, TMR_CMP_LO_OFS, TMR_CMP_HI_OFS};
    obi_req     = '0;
    arst_n_i    = 1'b0;
    boot_select = 1'b0;
    core_sleep  = 1'b0;
    model_reset();
    repeat (3) @(negedge clk_i);
    arst_n_i = 1'b1;

    // Reset values
    @(negedge clk_i);
    check_exit_outputs();
    check_equal(64'(timer_irq), 64'd0, "timer irq after reset");
    check_equal(64'(pg_switch), 64'd0, "power switch after reset");
    check_equal(64'(cpu_rst_n), 64'd1, "cpu reset after reset");
    check_equal(64'(obi_resp.gnt), 64'd0, "gnt after reset");
    check_equal(64'(obi_resp.rvalid), 64'd0, "rvalid after reset");
    read_expect(SOC_CTRL_IDX, SOC_EXIT_VALUE_OFS, "exit value after reset");
    read_expect(SOC_CTRL_IDX, SOC_EXIT_VALID_OFS, "exit flag after reset");
    read_expect(TIMER_IDX, TMR_CMP_LO_OFS, "compare low after reset");
    read_expect(TIMER_IDX, TMR_CMP_HI_OFS, "compare high after reset");
    obi_read(periph_addr(POWER_IDX, PWR_STATE_OFS), rdata);
    check_equal(64'(rdata), 64'(ACTIVE), "power state after reset");
    obi_read(periph_addr(POWER_IDX, PWR_WAKE_CNT_OFS), rdata);
    check_equal(64'(rdata), 64'd0, "wake count after reset");

    // Random register traffic with byte strobes
    for (int unsigned i = 0; i < N_RAND; i++) begin
      r    = next_random();
      d    = next_random();
      addr = periph_addr(tgt_idx[r[1:0]], tgt_ofs[r[1:0]]);
      if (r[6]) begin
        obi_write(addr, r[5:2], d);
        model_write(tgt_idx[r[1:0]], tgt_ofs[r[1:0]], r[5:2], d);
        check_exit_outputs();
      end else begin
        read_expect(tgt_idx[r[1:0]], tgt_ofs[r[1:0]], "random register read");
      end
    end

    // Boot select is read-only
    for (int unsigned i = 0; i < N_BOOT; i++) begin
      r = next_random();
      d = next_random();
      @(negedge clk_i);
      boot_select = r[0];
      m_boot_sel  = r[0];
      read_expect(SOC_CTRL_IDX, SOC_BOOT_SEL_OFS, "boot select read");
      obi_write(periph_addr(SOC_CTRL_IDX, SOC_BOOT_SEL_OFS), r[4:1], d);
      model_write(SOC_CTRL_IDX, SOC_BOOT_SEL_OFS, r[4:1], d);
      read_expect(SOC_CTRL_IDX, SOC_BOOT_SEL_OFS, "boot select after write");
      check_exit_outputs();
    end

    // Unmapped index 3 or outside the AO window
    for (int unsigned i = 0; i < N_UNMAPPED; i++) begin
      r = next_random();
      d = next_random();
      if (r[31]) begin
        addr = {AO_BASE[31:14], 2'b11, r[11:0]};
      end else begin
        addr = r;
        if (addr[31:14] == AO_BASE[31:14]) addr[31] = ~addr[31];
      end
      obi_access(r[12], r[16:13], addr, d, rdata, err);
      check_equal(64'(err), 64'd1, "error on unmapped access");
      check_equal(64'(rdata), 64'd0, "data on unmapped access");
    end
    for (int unsigned k = 0; k < 4; k++) begin
      read_expect(tgt_idx[k], tgt_ofs[k], "readback after unmapped access");
    end
    check_exit_outputs();

    // Timer rate and compare interrupt
    r     = next_random();
    presc = 32'(r[1:0]);
    obi_write(periph_addr(TIMER_IDX, TMR_PRESCALE_OFS), 4'hF, 32'(presc));
    obi_write(periph_addr(TIMER_IDX, TMR_CTRL_OFS), 4'hF, 32'h1);
    obi_read(periph_addr(TIMER_IDX, TMR_MTIME_LO_OFS), rdata);
    m1 = rdata;
    t1 = last_grant_cycle;
    repeat (8 + 32'(r[5:2])) @(negedge clk_i);
    obi_read(periph_addr(TIMER_IDX, TMR_MTIME_LO_OFS), rdata);
    m2 = rdata;
    t2 = last_grant_cycle;
    check_equal(64'(m2 >= m1), 64'd1, "mtime going backwards");
    check_equal(64'(m2 - m1 <= (t2 - t1) / (presc + 1) + 1), 64'd1, "mtime rate vs prescale");

    cmp_lo = m2 + 20 + 32'(r[9:6]);
    obi_write(periph_addr(TIMER_IDX, TMR_CMP_HI_OFS), 4'hF, 32'h0);
    model_write(TIMER_IDX, TMR_CMP_HI_OFS, 4'hF, 32'h0);
    obi_write(periph_addr(TIMER_IDX, TMR_CMP_LO_OFS), 4'hF, cmp_lo);
    model_write(TIMER_IDX, TMR_CMP_LO_OFS, 4'hF, cmp_lo);
    obi_write(periph_addr(TIMER_IDX, TMR_CTRL_OFS), 4'hF, 32'h3);
    reached = 1'b0;
    polls   = 0;
    while (!reached && polls < MTIME_POLL_MAX) begin
      obi_read(periph_addr(TIMER_IDX, TMR_MTIME_LO_OFS), rdata);
      polls++;
      if (rdata >= cmp_lo) begin
        check_equal(64'(timer_irq), 64'd1, "irq once mtime reaches compare");
        reached = 1'b1;
      end else begin
        check_equal(64'(timer_irq), 64'd0, "irq before mtime reaches compare");
      end
    end
    check_equal(64'(reached), 64'd1, "mtime reaching the compare value");
    obi_write(periph_addr(TIMER_IDX, TMR_CTRL_OFS), 4'hF, 32'h1);
    repeat (4) begin
      @(negedge clk_i);
      check_equal(64'(timer_irq), 64'd0, "irq after interrupt enable cleared");
    end

    // Sleep and wake through the power manager
    obi_write(periph_addr(POWER_IDX, PWR_EN_OFS), 4'hF, 32'h1);
    obi_read(periph_addr(TIMER_IDX, TMR_MTIME_LO_OFS), rdata);
    cmp_lo = rdata + 30;
    obi_write(periph_addr(TIMER_IDX, TMR_CMP_LO_OFS), 4'hF, cmp_lo);
    model_write(TIMER_IDX, TMR_CMP_LO_OFS, 4'hF, cmp_lo);
    obi_write(periph_addr(TIMER_IDX, TMR_CTRL_OFS), 4'hF, 32'h3);
    @(negedge clk_i);
    core_sleep = 1'b1;
    cyc      = 0;
    rst_fall = 0;
    sw_rise  = 0;
    irq_seen = 0;
    sw_fall  = 0;
    rst_rise = 0;
    while (rst_rise == 0 && cyc < SLEEP_BOUND) begin
      @(negedge clk_i);
      cyc++;
      check_equal(64'(pg_switch && cpu_rst_n), 64'd0, "switch high with reset released");
      if (rst_fall == 0 && !cpu_rst_n) begin
        rst_fall   = cyc;
        core_sleep = 1'b0;
      end
      if (sw_rise == 0 && pg_switch) sw_rise = cyc;
      if (sw_rise != 0 && irq_seen == 0) begin
        check_equal(64'(pg_switch), 64'd1, "switch held until interrupt");
      end
      if (sw_rise != 0 && irq_seen == 0 && timer_irq) irq_seen = cyc;
      if (sw_rise != 0 && sw_fall == 0 && !pg_switch) sw_fall = cyc;
      if (rst_fall != 0 && rst_rise == 0 && cpu_rst_n) rst_rise = cyc;
    end
    check_equal(64'(rst_rise != 0), 64'd1, "wake sequence completed");
    check_equal(64'(sw_rise), 64'(rst_fall + 1), "switch rise after reset fall");
    check_equal(64'(sw_fall), 64'(irq_seen + 1), "switch fall after interrupt");
    check_equal(64'(rst_rise), 64'(sw_fall + 1), "reset release after switch fall");
    obi_read(periph_addr(POWER_IDX, PWR_WAKE_CNT_OFS), rdata);
    check_equal(64'(rdata), 64'd1, "wake count after one sleep");
    obi_read(periph_addr(POWER_IDX, PWR_STATE_OFS), rdata);
    check_equal(64'(rdata), 64'(ACTIVE), "power state after wake");

    $display("TEST PASSED");
    $finish;
  end

endmodule : tb_ao_peripheral_subsystem

`default_nettype wire

//--- source/ao_peripheral_subsystem.sv
// ====================
// Always-on peripheral subsystem top
// ====================
`default_nettype none

module ao_peripheral_subsystem
  import ao_periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  obi_req_t    slave_req_i,
  output obi_resp_t   slave_resp_o,
  input  logic        boot_select_i,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o,
  input  logic        core_sleep_i,
  output logic        cpu_subsystem_powergate_switch_o,
  output logic        cpu_subsystem_rst_no,
  output logic        rv_timer_irq_o
);

  reg_req_t                     periph_req;
  reg_rsp_t                     periph_rsp;
  reg_req_t [AO_NUM_PERIPH-1:0] slv_req;
  reg_rsp_t [AO_NUM_PERIPH-1:0] slv_rsp;
  logic                         irq_timer;

  obi_to_reg obi_to_reg_i (
    .clk_i,
    .arst_n_i,
    .obi_req_i (slave_req_i),
    .obi_resp_o(slave_resp_o),
    .reg_req_o (periph_req),
    .reg_rsp_i (periph_rsp)
  );

  reg_demux reg_demux_i (
    .reg_req_i(periph_req),
    .reg_rsp_o(periph_rsp),
    .slv_req_o(slv_req),
    .slv_rsp_i(slv_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i(slv_req[SOC_CTRL_IDX]),
    .reg_rsp_o(slv_rsp[SOC_CTRL_IDX]),
    .boot_select_i,
    .exit_valid_o,
    .exit_value_o
  );

  rv_timer rv_timer_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i  (slv_req[TIMER_IDX]),
    .reg_rsp_o  (slv_rsp[TIMER_IDX]),
    .irq_timer_o(irq_timer)
  );

  power_manager power_manager_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i  (slv_req[POWER_IDX]),
    .reg_rsp_o  (slv_rsp[POWER_IDX]),
    .irq_timer_i(irq_timer),
    .core_sleep_i,
    .cpu_subsystem_powergate_switch_o,
    .cpu_subsystem_rst_no
  );

  assign rv_timer_irq_o = irq_timer;

endmodule : ao_peripheral_subsystem

`default_nettype wire

//--- source/power_manager.sv
// ====================
// Power manager: gates the CPU subsystem while the core
// sleeps, wakes it on the timer interrupt
// ====================
`default_nettype none

module power_manager
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  input  logic     irq_timer_i,
  input  logic     core_sleep_i,
  output logic     cpu_subsystem_powergate_switch_o,
  output logic     cpu_subsystem_rst_no
);

  logic [PERIPH_WINDOW_BITS-1:0] offset;
  logic                          wr_en;
  logic                          en_q;
  pwr_state_e                    state_q;
  pwr_state_e                    state_d;
  logic [15:0]                   wake_cnt_q;
  logic                          switch_q;
  logic                          rst_n_q;

  assign offset = reg_req_i.addr[PERIPH_WINDOW_BITS-1:0];
  assign wr_en  = reg_req_i.valid & reg_req_i.write;

  // One cycle per state, except ACTIVE and SLEEP
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ACTIVE:     if (core_sleep_i && en_q) state_d = RST_ON;
      RST_ON:     state_d = SWITCH_OFF;
      SWITCH_OFF: state_d = SLEEP;
      SLEEP:      if (irq_timer_i) state_d = SWITCH_ON;
      SWITCH_ON:  state_d = RST_OFF;
      RST_OFF:    state_d = ACTIVE;
      default:    state_d = ACTIVE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q       <= 1'b0;
      state_q    <= ACTIVE;
      wake_cnt_q <= 16'h0;
      switch_q   <= 1'b0;
      rst_n_q    <= 1'b1;
    end else begin
      if (wr_en && offset == PWR_EN_OFS && reg_req_i.wstrb[0]) en_q <= reg_req_i.wdata[0];
      state_q <= state_d;
      if (state_q == RST_OFF) wake_cnt_q <= wake_cnt_q + 16'd1;
      // Outputs follow the state being entered
      switch_q <= (state_d == SWITCH_OFF) || (state_d == SLEEP);
      rst_n_q  <= !(state_d inside {RST_ON, SWITCH_OFF, SLEEP, SWITCH_ON});
    end
  end

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    unique case (offset)
      PWR_EN_OFS:       reg_rsp_o.rdata = {31'h0, en_q};
      PWR_STATE_OFS:    reg_rsp_o.rdata = {29'h0, state_q};
      PWR_WAKE_CNT_OFS: reg_rsp_o.rdata = {16'h0, wake_cnt_q};
      default:          reg_rsp_o.rdata = 32'h0;
    endcase
  end

  assign cpu_subsystem_powergate_switch_o = switch_q;
  assign cpu_subsystem_rst_no             = rst_n_q;

  // Reset must already be held when the switch opens
  a_switch_in_reset : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cpu_subsystem_powergate_switch_o |-> !cpu_subsystem_rst_no && $past(!cpu_subsystem_rst_no));

endmodule : power_manager

`default_nettype wire

//--- source/rv_timer.sv
// ====================
// Machine timer: prescaled 64-bit mtime, compare, irq
// ====================
`default_nettype none

module rv_timer
  import ao_periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output logic     irq_timer_o
);

  logic [PERIPH_WINDOW_BITS-1:0] offset;
  logic                          wr_en;
  logic                          tick;
  logic [1:0]                    ctrl_q;
  logic [7:0]                    prescale_q;
  logic [7:0]                    presc_cnt_q;
  logic [63:0]                   mtime_q;
  logic [63:0]                   cmp_q;
  logic                          irq_q;

  assign offset = reg_req_i.addr[PERIPH_WINDOW_BITS-1:0];
  assign wr_en  = reg_req_i.valid & reg_req_i.write;
  // One tick every PRESCALE+1 cycles
  assign tick   = ctrl_q[0] && (presc_cnt_q >= prescale_q);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_q      <= 2'b00;
      prescale_q  <= 8'h0;
      presc_cnt_q <= 8'h0;
      mtime_q     <= 64'h0;
      cmp_q       <= '1;
      irq_q       <= 1'b0;
    end else begin
      presc_cnt_q <= (!ctrl_q[0] || tick) ? 8'h0 : presc_cnt_q + 8'd1;
      if (wr_en && offset == TMR_CTRL_OFS && reg_req_i.wstrb[0]) ctrl_q <= reg_req_i.wdata[1:0];
      if (wr_en && offset == TMR_PRESCALE_OFS && reg_req_i.wstrb[0]) begin
        prescale_q <= reg_req_i.wdata[7:0];
      end
      if (wr_en && offset == TMR_CMP_LO_OFS) begin
        cmp_q[31:0] <= apply_wstrb(cmp_q[31:0], reg_req_i.wdata, reg_req_i.wstrb);
      end
      if (wr_en && offset == TMR_CMP_HI_OFS) begin
        cmp_q[63:32] <= apply_wstrb(cmp_q[63:32], reg_req_i.wdata, reg_req_i.wstrb);
      end
      // Software write wins over the count
      if (wr_en && offset == TMR_MTIME_LO_OFS) begin
        mtime_q[31:0] <= apply_wstrb(mtime_q[31:0], reg_req_i.wdata, reg_req_i.wstrb);
      end else if (wr_en && offset == TMR_MTIME_HI_OFS) begin
        mtime_q[63:32] <= apply_wstrb(mtime_q[63:32], reg_req_i.wdata, reg_req_i.wstrb);
      end else if (tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
      irq_q <= ctrl_q[1] && (mtime_q >= cmp_q);
    end
  end

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    unique case (offset)
      TMR_CTRL_OFS:     reg_rsp_o.rdata = {30'h0, ctrl_q};
      TMR_PRESCALE_OFS: reg_rsp_o.rdata = {24'h0, prescale_q};
      TMR_MTIME_LO_OFS: reg_rsp_o.rdata = mtime_q[31:0];
      TMR_MTIME_HI_OFS: reg_rsp_o.rdata = mtime_q[63:32];
      TMR_CMP_LO_OFS:   reg_rsp_o.rdata = cmp_q[31:0];
      TMR_CMP_HI_OFS:   reg_rsp_o.rdata = cmp_q[63:32];
      default:          reg_rsp_o.rdata = 32'h0;
    endcase
  end

  assign irq_timer_o = irq_q;

  a_irq_needs_ie : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !ctrl_q[1] |=> !irq_timer_o);

endmodule : rv_timer

`default_nettype wire

//--- source/soc_ctrl.sv
// ====================
// SoC control: boot select, exit value and flag
// ====================
`default_nettype none

module soc_ctrl
  import ao_periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  reg_req_t    reg_req_i,
  output reg_rsp_t    reg_rsp_o,
  input  logic        boot_select_i,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o
);

  logic [PERIPH_WINDOW_BITS-1:0] offset;
  logic                          wr_en;
  logic                          exit_valid_q;
  logic [31:0]                   exit_value_q;

  assign offset = reg_req_i.addr[PERIPH_WINDOW_BITS-1:0];
  assign wr_en  = reg_req_i.valid & reg_req_i.write;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= 32'h0;
    end else if (wr_en) begin
      if (offset == SOC_EXIT_VALID_OFS && reg_req_i.wstrb[0]) exit_valid_q <= reg_req_i.wdata[0];
      if (offset == SOC_EXIT_VALUE_OFS) begin
        exit_value_q <= apply_wstrb(exit_value_q, reg_req_i.wdata, reg_req_i.wstrb);
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    unique case (offset)
      SOC_EXIT_VALID_OFS: reg_rsp_o.rdata = {31'h0, exit_valid_q};
      SOC_EXIT_VALUE_OFS: reg_rsp_o.rdata = exit_value_q;
      SOC_BOOT_SEL_OFS:   reg_rsp_o.rdata = {31'h0, boot_select_i};
      default:            reg_rsp_o.rdata = 32'h0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule : soc_ctrl

`default_nettype wire

//--- source/reg_demux.sv
// ====================
// Register bus demux: decodes the peripheral window,
// flags unmapped addresses
// ====================
`default_nettype none

module reg_demux
  import ao_periph_pkg::*;
(
  input  reg_req_t                     reg_req_i,
  output reg_rsp_t                     reg_rsp_o,
  output reg_req_t [AO_NUM_PERIPH-1:0] slv_req_o,
  input  reg_rsp_t [AO_NUM_PERIPH-1:0] slv_rsp_i
);

  localparam int unsigned SEL_LSB = PERIPH_WINDOW_BITS;
  localparam int unsigned BASE_LSB = PERIPH_WINDOW_BITS + PERIPH_SEL_BITS;

  logic                       in_base;
  logic [PERIPH_SEL_BITS-1:0] idx;
  logic                       mapped;
  logic [AO_NUM_PERIPH-1:0]   sel_valid;

  assign in_base = (reg_req_i.addr[31:BASE_LSB] == AO_BASE[31:BASE_LSB]);
  assign idx     = reg_req_i.addr[SEL_LSB+PERIPH_SEL_BITS-1:SEL_LSB];
  assign mapped  = in_base && (32'(idx) < AO_NUM_PERIPH);

  always_comb begin
    for (int i = 0; i < AO_NUM_PERIPH; i++) begin
      slv_req_o[i]       = reg_req_i;
      sel_valid[i]       = reg_req_i.valid && mapped && (32'(idx) == i);
      slv_req_o[i].valid = sel_valid[i];
    end
  end

  // Unmapped accesses are answered here with an error
  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b1;
    reg_rsp_o.rdata = 32'h0;
    for (int i = 0; i < AO_NUM_PERIPH; i++) begin
      if (mapped && (32'(idx) == i)) reg_rsp_o = slv_rsp_i[i];
    end
  end

  always_comb begin
    assert ($onehot0(sel_valid))
    else $error("reg_demux: more than one slave selected");
  end

endmodule : reg_demux

`default_nettype wire

//--- source/obi_to_reg.sv
// ====================
// OBI to register bus bridge, single cycle
// ====================
`default_nettype none

module obi_to_reg
  import ao_periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  obi_req_t  obi_req_i,
  output obi_resp_t obi_resp_o,
  output reg_req_t  reg_req_o,
  input  reg_rsp_t  reg_rsp_i
);

  logic        gnt;
  logic        rvalid_q;
  logic        err_q;
  logic [31:0] rdata_q;

  assign reg_req_o.valid = obi_req_i.req;
  assign reg_req_o.write = obi_req_i.we;
  assign reg_req_o.wstrb = obi_req_i.be;
  assign reg_req_o.addr  = obi_req_i.addr;
  assign reg_req_o.wdata = obi_req_i.wdata;

  // Slaves answer in the same cycle, so grant right away
  assign gnt = obi_req_i.req & reg_rsp_i.ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= gnt;
      err_q    <= gnt & reg_rsp_i.error;
    end
  end

  // Write responses return zero data
  always_ff @(posedge clk_i) begin
    rdata_q <= (gnt && !obi_req_i.we && !reg_rsp_i.error) ? reg_rsp_i.rdata : 32'h0;
  end

  assign obi_resp_o.gnt    = gnt;
  assign obi_resp_o.rvalid = rvalid_q;
  assign obi_resp_o.err    = err_q;
  assign obi_resp_o.rdata  = rdata_q;

  a_rvalid_after_gnt : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    obi_resp_o.rvalid |-> $past(obi_resp_o.gnt));

endmodule : obi_to_reg

`default_nettype wire

//--- source/ao_periph_pkg.sv
// ====================
// AO peripheral package: bus structs, address map,
// register offsets and power states
// ====================
`default_nettype none

package ao_periph_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  wstrb;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

  // Address map
  localparam int unsigned AO_NUM_PERIPH = 3;
  localparam int unsigned SOC_CTRL_IDX = 0;
  localparam int unsigned TIMER_IDX = 1;
  localparam int unsigned POWER_IDX = 2;
  localparam logic [31:0] AO_BASE = 32'h2000_0000;
  localparam int unsigned PERIPH_WINDOW_BITS = 12;
  localparam int unsigned PERIPH_SEL_BITS = 2;

  localparam logic [PERIPH_WINDOW_BITS-1:0] SOC_EXIT_VALID_OFS = 12'h000;
  localparam logic [PERIPH_WINDOW_BITS-1:0] SOC_EXIT_VALUE_OFS = 12'h004;
  localparam logic [PERIPH_WINDOW_BITS-1:0] SOC_BOOT_SEL_OFS = 12'h008;

  localparam logic [PERIPH_WINDOW_BITS-1:0] TMR_CTRL_OFS = 12'h000;
  localparam logic [PERIPH_WINDOW_BITS-1:0] TMR_PRESCALE_OFS = 12'h004;
  localparam logic [PERIPH_WINDOW_BITS-1:0] TMR_MTIME_LO_OFS = 12'h008;
  localparam logic [PERIPH_WINDOW_BITS-1:0] TMR_MTIME_HI_OFS = 12'h00C;
  localparam logic [PERIPH_WINDOW_BITS-1:0] TMR_CMP_LO_OFS = 12'h010;
  localparam logic [PERIPH_WINDOW_BITS-1:0] TMR_CMP_HI_OFS = 12'h014;

  localparam logic [PERIPH_WINDOW_BITS-1:0] PWR_EN_OFS = 12'h000;
  localparam logic [PERIPH_WINDOW_BITS-1:0] PWR_STATE_OFS = 12'h004;
  localparam logic [PERIPH_WINDOW_BITS-1:0] PWR_WAKE_CNT_OFS = 12'h008;

  typedef enum logic [2:0] {
    ACTIVE,
    RST_ON,
    SWITCH_OFF,
    SLEEP,
    SWITCH_ON,
    RST_OFF
  } pwr_state_e;

  // Byte-lane merge of a write into an old register value
  function automatic logic [31:0] apply_wstrb(logic [31:0] old_val, logic [31:0] new_val,
                                              logic [3:0] strb);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b+:8] = new_val[8*b+:8];
    end
    return res;
  endfunction

endpackage : ao_periph_pkg

`default_nettype wire
